// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := fpu_pipe_tb
FILELIST  := sources.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/fp_format_pkg.sv
// single precision format package
// field widths, bias and the unpacked operand record shared by all stages

package fp_format_pkg;

  // packed word layout is sign, exponent, fraction from msb to lsb
  localparam int exp_width  = 8;
  localparam int frac_width = 23;

  // fraction with the hidden bit in front
  localparam int mant_width = frac_width + 1;

  localparam int exp_bias   = 127;

  // also the width of the converted integer
  localparam int word_width = 32;

  // bit positions inside a packed word
  localparam int sign_pos   = word_width - 1;
  localparam int exp_lsb    = frac_width;
  localparam int exp_msb    = frac_width + exp_width - 1;

  // one operand after unpacking, 33 bits
  // mant holds 1.fraction for normal numbers
  // denormals keep a zero hidden bit
  typedef struct packed {
    logic                  sign;
    logic [exp_width-1:0]  exp;
    logic [mant_width-1:0] mant;
  } fp_unpacked_t;

  // zero operand, used as the reset value of the links
  localparam fp_unpacked_t fp_unpacked_zero = '{
    sign: 1'b0,
    exp:  '0,
    mant: '0
  };

endpackage

// File: hw/fpu_execute_stage.sv
// second pipeline stage
// aligned add/sub, mantissa product and float to integer extraction
`timescale 1ns/1ps

module fpu_execute_stage (
  input  logic       clk,
  input  logic       arst,
  fpu_operand_if.dst in,
  fpu_result_if.src  out
);

  // add/sub datapath
  logic                                a_small;
  logic [fp_format_pkg::exp_width-1:0] exp_shift;
  logic [fp_format_pkg::exp_width-1:0] exp_max;
  logic [fpu_op_pkg::sum_width-1:0]    a_align;
  logic [fpu_op_pkg::sum_width-1:0]    b_align;
  logic [fpu_op_pkg::sum_width-1:0]    a_twos;
  logic [fpu_op_pkg::sum_width-1:0]    b_twos;
  logic [fpu_op_pkg::sum_width-1:0]    sum;
  logic                                sum_sign;
  logic [fpu_op_pkg::sum_width-1:0]    sum_mag;

  // mul datapath
  logic [fpu_op_pkg::prod_width-1:0]    product;
  logic [fpu_op_pkg::raw_exp_width-1:0] mul_exp;

  // float to int datapath
  logic [fpu_op_pkg::raw_exp_width-1:0] unbiased;
  logic [fp_format_pkg::word_width-1:0] mant_word;
  logic [fp_format_pkg::word_width-1:0] int_val;

  fpu_op_pkg::raw_result_t raw_next;

  // the operand with the smaller exponent is shifted right, bits falling off are lost
  assign a_small   = in.a.exp < in.b.exp;
  assign exp_shift = a_small ? in.b.exp - in.a.exp : in.a.exp - in.b.exp;
  assign exp_max   = a_small ? in.b.exp : in.a.exp;
  assign a_align   = a_small ? fpu_op_pkg::sum_width'(in.a.mant) >> exp_shift
                             : fpu_op_pkg::sum_width'(in.a.mant);
  assign b_align   = a_small ? fpu_op_pkg::sum_width'(in.b.mant)
                             : fpu_op_pkg::sum_width'(in.b.mant) >> exp_shift;

  // two's complement for negative operands
  // bit 25 becomes the sign, bit 24 keeps room for the carry out of bit 23
  assign a_twos = in.a.sign ? ~a_align + 1'b1 : a_align;
  assign b_twos = in.b.sign ? ~b_align + 1'b1 : b_align;
  assign sum    = (in.op == fpu_op_pkg::op_sub) ? a_twos - b_twos : a_twos + b_twos;

  assign sum_sign = sum[fpu_op_pkg::sum_width-1];
  assign sum_mag  = sum_sign ? ~sum + 1'b1 : sum;

  // unsigned 24x24 product, biased exponent sum minus one bias
  assign product = in.a.mant * in.b.mant;
  assign mul_exp = fpu_op_pkg::raw_exp_width'(in.a.exp) + fpu_op_pkg::raw_exp_width'(in.b.exp)
                   - fpu_op_pkg::raw_exp_width'(fp_format_pkg::exp_bias);

  // float to int ignores the sign
  // the binary point sits above bit 22 of the mantissa, move it by the unbiased exponent
  assign unbiased  = fpu_op_pkg::raw_exp_width'(in.a.exp)
                     - fpu_op_pkg::raw_exp_width'(fp_format_pkg::exp_bias);
  assign mant_word = fp_format_pkg::word_width'(in.a.mant);

  always_comb begin
    if (unbiased[fpu_op_pkg::raw_exp_width-1]) begin
      // below one
      int_val = '0;
    end else if (unbiased <= fpu_op_pkg::raw_exp_width'(fp_format_pkg::frac_width)) begin
      int_val = mant_word >> (fp_format_pkg::frac_width - unbiased);
    end else begin
      // exact only up to an unbiased exponent of 30
      int_val = mant_word << (unbiased - fp_format_pkg::frac_width);
    end
  end

  // pick the raw fields of the selected operation
  always_comb begin
    raw_next = '0;
    case (in.op)
      fpu_op_pkg::op_add, fpu_op_pkg::op_sub: begin
        raw_next.sign = sum_sign;
        raw_next.exp  = fpu_op_pkg::raw_exp_width'(exp_max);
        raw_next.mant = fpu_op_pkg::prod_width'(sum_mag);
      end
      fpu_op_pkg::op_mul: begin
        raw_next.sign = in.a.sign ^ in.b.sign;
        raw_next.exp  = mul_exp;
        raw_next.mant = product;
      end
      default: begin
        raw_next.int_val = int_val;
      end
    endcase
  end

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      out.valid <= 1'b0;
      out.op    <= fpu_op_pkg::op_add;
      out.raw   <= '0;
    end else begin
      out.valid <= in.valid;
      out.op    <= in.op;
      out.raw   <= raw_next;
    end
  end

endmodule

// File: hw/fpu_normalize_stage.sv
// third pipeline stage
// normalizes add/sub and product results, rounds the product and packs the word
`timescale 1ns/1ps

module fpu_normalize_stage (
  input  logic                                 clk,
  input  logic                                 arst,
  fpu_result_if.dst                            in,
  output logic                                 out_valid,
  output logic [fp_format_pkg::word_width-1:0] out_result
);

  // add/sub path
  logic [fpu_op_pkg::sum_width-1:0]     sum_mag;
  logic [4:0]                           zero_count;
  logic [fpu_op_pkg::sum_width-1:0]     sum_norm;
  logic [fpu_op_pkg::raw_exp_width-1:0] sum_exp;
  logic [fp_format_pkg::word_width-1:0] addsub_word;

  // mul path
  logic [fpu_op_pkg::prod_width-1:0]    prod_norm;
  logic [fpu_op_pkg::raw_exp_width-1:0] prod_exp;
  logic                                 round_up;
  logic [fp_format_pkg::mant_width:0]   prod_round;
  logic [fp_format_pkg::mant_width-1:0] mul_mant;
  logic [fpu_op_pkg::raw_exp_width-1:0] mul_exp;
  logic [fp_format_pkg::word_width-1:0] mul_word;

  logic [fp_format_pkg::word_width-1:0] result_next;

  // leading zeros above the hidden bit position, 24 for an all zero value
  function automatic logic [4:0] lead_zeros(
    input logic [fp_format_pkg::mant_width-1:0] v
  );
    logic [4:0] n;
    n = 5'(fp_format_pkg::mant_width);
    // highest set bit wins
    for (int i = 0; i < fp_format_pkg::mant_width; i++) begin
      if (v[i]) n = 5'(fp_format_pkg::mant_width - 1 - i);
    end
    return n;
  endfunction

  assign sum_mag    = in.raw.mant[fpu_op_pkg::sum_width-1:0];
  assign zero_count = lead_zeros(sum_mag[fp_format_pkg::mant_width-1:0]);

  // carry into bit 24 shifts right, otherwise shift left until bit 23 is set
  always_comb begin
    if (sum_mag == '0) begin
      sum_norm = '0;
      sum_exp  = '0;
    end else if (sum_mag[fp_format_pkg::mant_width]) begin
      sum_norm = sum_mag >> 1;
      sum_exp  = in.raw.exp + 1'b1;
    end else begin
      sum_norm = sum_mag << zero_count;
      sum_exp  = in.raw.exp - fpu_op_pkg::raw_exp_width'(zero_count);
    end
  end

  // exact cancellation packs as +0
  assign addsub_word = (sum_mag == '0) ? '0 :
                       {in.raw.sign, sum_exp[fp_format_pkg::exp_width-1:0],
                        sum_norm[fp_format_pkg::frac_width-1:0]};

  // product is 1x.xx or 01.xx, bring the leading one to bit 47
  assign prod_norm = in.raw.mant[fpu_op_pkg::prod_width-1] ? in.raw.mant : in.raw.mant << 1;
  assign prod_exp  = in.raw.mant[fpu_op_pkg::prod_width-1] ? in.raw.exp + 1'b1 : in.raw.exp;

  // nearest even
  // guard is bit 23, sticky is everything below, lsb is bit 24
  assign round_up   = prod_norm[fp_format_pkg::mant_width-1] &&
                      (|prod_norm[fp_format_pkg::mant_width-2:0] ||
                       prod_norm[fp_format_pkg::mant_width]);
  assign prod_round = {1'b0, prod_norm[fpu_op_pkg::prod_width-1:fp_format_pkg::mant_width]}
                      + round_up;

  // rounding 1.11..1 up gives 10.00..0, renormalize once more
  assign mul_mant = prod_round[fp_format_pkg::mant_width] ?
                    prod_round[fp_format_pkg::mant_width:1] :
                    prod_round[fp_format_pkg::mant_width-1:0];
  assign mul_exp  = prod_round[fp_format_pkg::mant_width] ? prod_exp + 1'b1 : prod_exp;
  assign mul_word = {in.raw.sign, mul_exp[fp_format_pkg::exp_width-1:0],
                     mul_mant[fp_format_pkg::frac_width-1:0]};

  always_comb begin
    case (in.op)
      fpu_op_pkg::op_add, fpu_op_pkg::op_sub: result_next = addsub_word;
      fpu_op_pkg::op_mul:                     result_next = mul_word;
      default:                                result_next = in.raw.int_val;
    endcase
  end

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      out_valid  <= 1'b0;
      out_result <= '0;
    end else begin
      out_valid  <= in.valid;
      out_result <= result_next;
    end
  end

endmodule

// File: hw/fpu_op_pkg.sv
// operation package for the pipelined fpu
// op codes, the raw result passed from execute to normalize, and latency

package fpu_op_pkg;

  // two bit operation code
  typedef enum logic [1:0] {
    op_add          = 2'd0,
    op_sub          = 2'd1,
    op_mul          = 2'd2,
    op_float_to_int = 2'd3
  } fpu_op_t;

  // 24 bit mantissa plus one carry bit and one sign guard bit
  localparam int sum_width  = 26;

  // full 24x24 mantissa product
  localparam int prod_width = 48;

  // raw exponent is wide enough to hold a biased sum before normalization
  localparam int raw_exp_width = 10;

  // one unnormalized result
  // exp is two's complement, mant holds the add/sub magnitude in its
  // low sum_width bits or the full product, int_val the converted integer
  typedef struct packed {
    logic                                sign;
    logic [raw_exp_width-1:0]            exp;
    logic [prod_width-1:0]               mant;
    logic [fp_format_pkg::word_width-1:0] int_val;
  } raw_result_t;

  // one register per stage: unpack, execute, normalize
  localparam int pipe_latency = 3;

endpackage

// File: hw/fpu_operand_if.sv
// operand link between the unpack and execute stages
// valid qualifies op and both unpacked operands without a ready
`timescale 1ns/1ps

interface fpu_operand_if;

  // high for one cycle per operation
  logic valid;

  fpu_op_pkg::fpu_op_t        op;
  fp_format_pkg::fp_unpacked_t a;
  fp_format_pkg::fp_unpacked_t b;

  // unpack stage drives the link
  modport src (output valid, output op, output a, output b);

  // execute stage samples it on every edge where valid is high
  modport dst (input valid, input op, input a, input b);

endinterface

// File: hw/fpu_pipe_top.sv
// pipelined single precision fpu
// add, sub, mul and float to int over three stages, one op per clock
`timescale 1ns/1ps

module fpu_pipe_top (
  input  logic                                 clk,
  input  logic                                 arst,
  input  logic                                 in_valid,
  input  fpu_op_pkg::fpu_op_t                  in_op,
  input  logic [fp_format_pkg::word_width-1:0] in_a,
  input  logic [fp_format_pkg::word_width-1:0] in_b,
  output logic                                 out_valid,
  output logic [fp_format_pkg::word_width-1:0] out_result
);

  // unpack to execute
  fpu_operand_if operand_link ();

  // execute to normalize
  fpu_result_if result_link ();

  // stage 1
  // split the packed words
  fpu_unpack_stage unpack_i (
    .clk      (clk),
    .arst     (arst),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_a     (in_a),
    .in_b     (in_b),
    .out      (operand_link.src)
  );

  // stage 2
  // align and add, multiply or extract the integer
  fpu_execute_stage execute_i (
    .clk  (clk),
    .arst (arst),
    .in   (operand_link.dst),
    .out  (result_link.src)
  );

  // stage 3
  // normalize, round the product and pack
  fpu_normalize_stage normalize_i (
    .clk        (clk),
    .arst       (arst),
    .in         (result_link.dst),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

endmodule

// File: hw/fpu_result_if.sv
// raw result link between the execute and normalize stages
// valid qualifies op and the unnormalized result, no ready
`timescale 1ns/1ps

interface fpu_result_if;

  // high for one cycle per operation
  logic valid;

  // op travels along so the last stage knows how to pack
  fpu_op_pkg::fpu_op_t     op;

  // sign, raw exponent, wide mantissa and converted integer
  fpu_op_pkg::raw_result_t raw;

  // execute stage drives the link
  modport src (output valid, output op, output raw);

  // normalize stage reads it
  modport dst (input valid, input op, input raw);

endinterface

// File: hw/fpu_unpack_stage.sv
// first pipeline stage
// registers each operand split into sign, exponent and mantissa
`timescale 1ns/1ps

module fpu_unpack_stage (
  input  logic                                 clk,
  input  logic                                 arst,
  input  logic                                 in_valid,
  input  fpu_op_pkg::fpu_op_t                  in_op,
  input  logic [fp_format_pkg::word_width-1:0] in_a,
  input  logic [fp_format_pkg::word_width-1:0] in_b,
  fpu_operand_if.src                           out
);

  fp_format_pkg::fp_unpacked_t a_split;
  fp_format_pkg::fp_unpacked_t b_split;

  // split one packed word
  // hidden bit only for a nonzero exponent, so denormals stay 0.fraction
  function automatic fp_format_pkg::fp_unpacked_t split_word(
    input logic [fp_format_pkg::word_width-1:0] w
  );
    fp_format_pkg::fp_unpacked_t u;
    u.sign = w[fp_format_pkg::sign_pos];
    u.exp  = w[fp_format_pkg::exp_msb:fp_format_pkg::exp_lsb];
    u.mant = {u.exp != '0, w[fp_format_pkg::frac_width-1:0]};
    return u;
  endfunction

  assign a_split = split_word(in_a);
  assign b_split = split_word(in_b);

  // payload follows the input every cycle
  // the valid bit alone tells the next stage whether to use it
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      out.valid <= 1'b0;
      out.op    <= fpu_op_pkg::op_add;
      out.a     <= fp_format_pkg::fp_unpacked_zero;
      out.b     <= fp_format_pkg::fp_unpacked_zero;
    end else begin
      out.valid <= in_valid;
      out.op    <= in_op;
      out.a     <= a_split;
      out.b     <= b_split;
    end
  end

endmodule

// File: sim/fpu_input_vectors.txt
// columns: op a b expected, all hex
// op 0 add, 1 sub, 2 mul, 3 float to int (b unused)
0 3f800000 3f800000 40000000
0 3f800000 40000000 40400000
0 3f800000 33800000 3f800000
0 3f800000 3f800003 40000001
0 bfc00000 3f000000 bf800000
1 40400000 3f800000 40000000
1 40a00000 40a00000 00000000
1 3f800000 3f400000 3e800000
1 3f800000 40000000 bf800000
2 40000000 40400000 40c00000
2 3fc00000 3fc00000 40100000
2 c0000000 3f400000 bfc00000
2 3f918e00 3fe12000 40000000
2 3f800001 3fc00000 3fc00002
2 3f800003 3fc00000 3fc00004
3 3f800000 00000000 00000001
3 3f000000 00000000 00000000
3 42f78000 00000000 0000007b
3 c0f00000 00000000 00000007
3 4b000001 00000000 00800001
3 4b800001 00000000 01000002
3 4ec00000 00000000 60000000

// File: sim/fpu_pipe_assertions.sv
// timing checks on the fpu pipeline top level
// bound into the top so they watch its ports directly
`timescale 1ns/1ps

module fpu_pipe_assertions (
  input logic                                 clk,
  input logic                                 arst,
  input logic                                 in_valid,
  input logic                                 out_valid,
  input logic [fp_format_pkg::word_width-1:0] out_result
);

  // every accepted operation leaves exactly pipe_latency edges later
  property valid_latency;
    @(posedge clk) disable iff (arst)
      in_valid |-> ##(fpu_op_pkg::pipe_latency) out_valid;
  endproperty

  // no output without an input pipe_latency edges back
  property valid_has_source;
    @(posedge clk) disable iff (arst)
      out_valid |-> $past(in_valid, fpu_op_pkg::pipe_latency);
  endproperty

  // result fully known while qualified
  property result_known;
    @(posedge clk) disable iff (arst)
      out_valid |-> !$isunknown(out_result);
  endproperty

  valid_latency_a:    assert property (valid_latency)
    else $error("out_valid missing after in_valid");
  valid_has_source_a: assert property (valid_has_source)
    else $error("out_valid without a matching in_valid");
  result_known_a:     assert property (result_known)
    else $error("out_result has unknown bits while out_valid is high");

endmodule

// File: sim/fpu_pipe_tb.sv
// testbench for the pipelined fpu
// replays the vector file twice, first with random idle gaps and then back to back
`timescale 1ns/1ps

module fpu_pipe_tb;

  localparam int max_vectors  = 64;
  localparam int words_per_op = 4;
  localparam int drain_limit  = 20;

  logic                                 clk;
  logic                                 arst;
  logic                                 in_valid;
  fpu_op_pkg::fpu_op_t                  in_op;
  logic [fp_format_pkg::word_width-1:0] in_a;
  logic [fp_format_pkg::word_width-1:0] in_b;
  logic                                 out_valid;
  logic [fp_format_pkg::word_width-1:0] out_result;

  // four words per operation in the order op, a, b and expected result
  logic [31:0] vec_mem [0:max_vectors*words_per_op-1];
  int          vec_count;

  // one entry per operation in flight with the oldest first
  logic [31:0] exp_result_q [$];
  int          exp_due_q [$];
  int          exp_index_q [$];

  // negedge counter used as the time base for arrival checks
  int neg_count     = 0;
  int value_errors  = 0;
  int timing_errors = 0;
  int other_errors  = 0;

  fpu_pipe_top dut_i (
    .clk        (clk),
    .arst       (arst),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_a       (in_a),
    .in_b       (in_b),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  bind fpu_pipe_top fpu_pipe_assertions assert_i (
    .clk        (clk),
    .arst       (arst),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // fill with an address dependent marker and then count lines with a legal op code
  task automatic load_vectors();
    for (int k = 0; k < max_vectors * words_per_op; k++) begin
      vec_mem[k] = {16'hf0f0, 16'(k)};
    end
    $readmemh("sim/fpu_input_vectors.txt", vec_mem);
    vec_count = 0;
    while (vec_count < max_vectors && vec_mem[vec_count * words_per_op] <= 32'd3) begin
      vec_count++;
    end
  endtask

  // drive one vector and record what should come out and when
  task automatic issue_op(input int index);
    int base;
    base = index * words_per_op;
    in_valid <= 1'b1;
    in_op    <= fpu_op_pkg::fpu_op_t'(vec_mem[base][1:0]);
    in_a     <= vec_mem[base + 1];
    in_b     <= vec_mem[base + 2];
    exp_result_q.push_back(vec_mem[base + 3]);
    // sampled at the next edge and visible pipe_latency negedges after that
    exp_due_q.push_back(neg_count + 1 + fpu_op_pkg::pipe_latency);
    exp_index_q.push_back(index);
  endtask

  // all vectors once with gaps of 0 to 2 idle cycles when asked
  task automatic run_pass(input bit with_gaps);
    int gap;
    for (int i = 0; i < vec_count; i++) begin
      gap = with_gaps ? int'($urandom % 3) : 0;
      repeat (gap) begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
      @(posedge clk);
      issue_op(i);
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // outputs settle after the rising edge and are looked at half a cycle later
  task automatic check_output();
    logic [31:0] expected;
    int          due;
    int          index;
    if ($isunknown(out_valid)) begin
      $display("out_valid is unknown at time %0t", $time);
      other_errors++;
    end else if (out_valid) begin
      if (exp_result_q.size() == 0) begin
        $display("out_valid went high at time %0t with no operation in flight", $time);
        other_errors++;
      end else begin
        expected = exp_result_q.pop_front();
        due      = exp_due_q.pop_front();
        index    = exp_index_q.pop_front();
        if (out_result !== expected) begin
          $display("Error at time %0t: out_result expected %h actual %h (vector %0d)",
                   $time, expected, out_result, index);
          value_errors++;
        end
        if (neg_count != due) begin
          $display("Error at time %0t: out_valid cycle expected %0d actual %0d (vector %0d)",
                   $time, due, neg_count, index);
          timing_errors++;
        end
      end
    end else if (exp_due_q.size() != 0 && exp_due_q[0] <= neg_count) begin
      // an overdue result is dropped so later ones still line up
      $display("result of vector %0d did not appear at cycle %0d",
               exp_index_q[0], exp_due_q[0]);
      void'(exp_result_q.pop_front());
      void'(exp_due_q.pop_front());
      void'(exp_index_q.pop_front());
      other_errors++;
    end
  endtask

  always @(negedge clk) begin
    neg_count = neg_count + 1;
    check_output();
  end

  // wait until every issued operation has come out
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_result_q.size() != 0 && waited < drain_limit) begin
      @(posedge clk);
      waited++;
    end
    if (exp_result_q.size() != 0) begin
      $display("timed out after %0d cycles with %0d results still missing",
               waited, exp_result_q.size());
      other_errors++;
    end
  endtask

  initial begin
    void'($urandom(32'hf941));
    arst     = 1'b1;
    in_valid = 1'b0;
    in_op    = fpu_op_pkg::op_add;
    in_a     = '0;
    in_b     = '0;
    load_vectors();
    if (vec_count == 0) begin
      $display("no vectors were read from the input file");
      other_errors++;
    end
    repeat (4) @(posedge clk);
    arst <= 1'b0;
    // idle after reset while out_valid must stay low
    repeat (3) @(posedge clk);
    run_pass(1'b1);
    // back to back keeps three operations in flight
    run_pass(1'b0);
    wait_drain();
    // trailing idle cycles catch a stray out_valid
    repeat (4) @(posedge clk);
    $display("errors: %0d value, %0d timing, %0d other",
             value_errors, timing_errors, other_errors);
    if (value_errors + timing_errors + other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: sources.f
hw/fp_format_pkg.sv
hw/fpu_op_pkg.sv
hw/fpu_operand_if.sv
hw/fpu_result_if.sv
hw/fpu_unpack_stage.sv
hw/fpu_execute_stage.sv
hw/fpu_normalize_stage.sv
hw/fpu_pipe_top.sv
sim/fpu_pipe_assertions.sv
sim/fpu_pipe_tb.sv
